// File: fsq_pkg.sv
package fsq_pkg;

    // queue geometry
    localparam int fsq_size = 16;
    localparam int fsq_width = $clog2(fsq_size);

    localparam int vaddr_size = 32;

    // fetch block and offset width
    localparam int block_inst_size = 8;
    localparam int prediction_width = $clog2(block_inst_size);

    // backend retire bandwidth
    localparam int commit_width = 4;

    // one block of pending instructions plus a cycle of commits
    localparam int commit_cnt_width = $clog2(block_inst_size + commit_width) + 1;

    typedef logic [fsq_width-1:0] fsq_idx_t;

    typedef logic [vaddr_size-1:0] vaddr_t;

    typedef logic [prediction_width-1:0] offset_t;

    typedef logic [$clog2(commit_width + 1)-1:0] commit_num_t;

    typedef logic [commit_cnt_width-1:0] commit_cnt_t;

    // four-phase issue towards the icache
    typedef enum logic [1:0] {
        fetch_idle    = 2'd0,
        fetch_req     = 2'd1,
        fetch_release = 2'd2
    } fetch_state_t;

endpackage

// File: stream_ram.sv
`timescale 1ns/100ps

module stream_ram
    import fsq_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     enq_en,
    input  fsq_idx_t enq_idx,
    input  vaddr_t   enq_start_addr,
    input  offset_t  enq_size,
    input  logic     redirect_en,
    input  fsq_idx_t redirect_idx,
    input  offset_t  redirect_offset,
    input  fsq_idx_t search_idx,
    input  fsq_idx_t commit_idx,
    output vaddr_t   search_start_addr,
    output offset_t  search_size,
    output vaddr_t   commit_start_addr,
    output offset_t  commit_size,
    output logic     commit_truncated,
    output offset_t  commit_trunc_offset
);

    vaddr_t              start_addr_mem [fsq_size];
    offset_t             size_mem       [fsq_size];
    offset_t             trunc_off_mem  [fsq_size];
    logic [fsq_size-1:0] trunc_flag;

    // stream payload, written by the predictor
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < fsq_size; i++) begin
                start_addr_mem[i] <= '0;
                size_mem[i] <= '0;
            end
        end else if (enq_en) begin
            start_addr_mem[enq_idx] <= enq_start_addr;
            size_mem[enq_idx] <= enq_size;
        end
    end

    // truncation info, owned by backend redirects
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            trunc_flag <= '0;
            for (int i = 0; i < fsq_size; i++) begin
                trunc_off_mem[i] <= '0;
            end
        end else begin
            if (enq_en) begin
                trunc_flag[enq_idx] <= 1'b0;
            end
            // later assignment wins if both hit one entry
            if (redirect_en) begin
                trunc_flag[redirect_idx] <= 1'b1;
                trunc_off_mem[redirect_idx] <= redirect_offset;
            end
        end
    end

    // icache read port
    assign search_start_addr = start_addr_mem[search_idx];
    assign search_size = size_mem[search_idx];

    // retire read port
    assign commit_start_addr = start_addr_mem[commit_idx];
    assign commit_size = size_mem[commit_idx];
    assign commit_truncated = trunc_flag[commit_idx];
    assign commit_trunc_offset = trunc_off_mem[commit_idx];

endmodule

// File: fsq_pointers.sv
`timescale 1ns/100ps

module fsq_pointers
    import fsq_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     enq_valid,
    input  logic     redirect_en,
    input  fsq_idx_t redirect_idx,
    input  logic     fetch_done,
    input  logic     retire,
    output fsq_idx_t tail,
    output fsq_idx_t search_head,
    output fsq_idx_t commit_head,
    output logic     full,
    output logic     fetch_pending,
    output logic     enq_en
);

    logic                 tail_dir;
    logic                 search_dir;
    logic                 commit_dir;
    logic                 redirect_dir;
    logic [fsq_width:0]   redirect_ptr_n1;

    // live entries below the commit head index are one lap ahead
    assign redirect_dir = (redirect_idx >= commit_head) ? commit_dir : ~commit_dir;

    // dir bit on top, so the carry out of the index flips it
    assign redirect_ptr_n1 = {redirect_dir, redirect_idx} + 1'b1;

    assign full = (tail == commit_head) && (tail_dir != commit_dir);
    assign fetch_pending = (search_head != tail) || (search_dir != tail_dir);

    // enqueue is dropped in a redirect cycle
    assign enq_en = enq_valid && !full && !redirect_en;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tail <= '0;
            tail_dir <= 1'b0;
        end else if (redirect_en) begin
            {tail_dir, tail} <= redirect_ptr_n1;
        end else if (enq_en) begin
            {tail_dir, tail} <= {tail_dir, tail} + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            search_head <= '0;
            search_dir <= 1'b0;
        end else if (redirect_en) begin
            // refetch from the stream after the mispredicted one
            {search_dir, search_head} <= redirect_ptr_n1;
        end else if (fetch_done) begin
            {search_dir, search_head} <= {search_dir, search_head} + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit_head <= '0;
            commit_dir <= 1'b0;
        end else if (retire) begin
            {commit_dir, commit_head} <= {commit_dir, commit_head} + 1'b1;
        end
    end

endmodule

// File: fetch_issue.sv
`timescale 1ns/100ps

module fetch_issue
    import fsq_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic fetch_pending,
    input  logic redirect_en,
    input  logic fetch_ack,
    output logic fetch_req,
    output logic fetch_flush,
    output logic fetch_done
);

    fetch_state_t state;

    // ack seen while requesting, a redirect cancels the advance
    assign fetch_done = (state == fsq_pkg::fetch_req) && fetch_ack && !redirect_en;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= fsq_pkg::fetch_idle;
            fetch_req <= 1'b0;
        end else begin
            case (state)
                fsq_pkg::fetch_idle: begin
                    // previous ack must be gone before a new req
                    if (!redirect_en && fetch_pending && !fetch_ack) begin
                        state <= fsq_pkg::fetch_req;
                        fetch_req <= 1'b1;
                    end
                end
                fsq_pkg::fetch_req: begin
                    if (redirect_en || fetch_ack) begin
                        state <= fsq_pkg::fetch_release;
                        fetch_req <= 1'b0;
                    end
                end
                fsq_pkg::fetch_release: begin
                    if (!fetch_ack) begin
                        state <= fsq_pkg::fetch_idle;
                    end
                end
                default: begin
                    state <= fsq_pkg::fetch_idle;
                    fetch_req <= 1'b0;
                end
            endcase
        end
    end

    // one cycle flush pulse after a backend redirect
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fetch_flush <= 1'b0;
        end else begin
            fetch_flush <= redirect_en;
        end
    end

endmodule

// File: commit_tracker.sv
`timescale 1ns/100ps

module commit_tracker
    import fsq_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  commit_num_t commit_num,
    input  vaddr_t      commit_start_addr,
    input  offset_t     commit_size,
    input  logic        commit_truncated,
    input  offset_t     commit_trunc_offset,
    output logic        retire,
    output logic        update_valid,
    output vaddr_t      update_start_addr,
    output offset_t     update_size,
    output logic        update_mispred
);

    commit_cnt_t               commit_cnt;
    commit_cnt_t               commit_cnt_n;
    offset_t                   eff_size;
    logic [prediction_width:0] stream_len;

    // a truncated stream ends at the redirect offset
    assign eff_size = commit_truncated ? commit_trunc_offset : commit_size;
    assign stream_len = {1'b0, eff_size} + 1'b1;

    assign retire = commit_cnt >= commit_cnt_t'(stream_len);

    always_comb begin
        commit_cnt_n = commit_cnt + commit_cnt_t'(commit_num);
        if (retire) begin
            commit_cnt_n = commit_cnt_n - commit_cnt_t'(stream_len);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit_cnt <= '0;
            update_valid <= 1'b0;
        end else begin
            commit_cnt <= commit_cnt_n;
            update_valid <= retire;
        end
    end

    // update payload to the predictor
    always_ff @(posedge clk) begin
        if (retire) begin
            update_start_addr <= commit_start_addr;
            update_size <= eff_size;
            update_mispred <= commit_truncated;
        end
    end

endmodule

// File: fsq_top.sv
`timescale 1ns/100ps

module fsq_top
    import fsq_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        pred_valid,
    input  vaddr_t      pred_start_addr,
    input  offset_t     pred_size,
    output logic        pred_stall,
    output fsq_idx_t    pred_idx,
    output logic        fetch_req,
    input  logic        fetch_ack,
    output logic        fetch_flush,
    output fsq_idx_t    fetch_idx,
    output vaddr_t      fetch_start_addr,
    output offset_t     fetch_size,
    input  logic        redirect_en,
    input  fsq_idx_t    redirect_idx,
    input  offset_t     redirect_offset,
    input  commit_num_t commit_num,
    output logic        update_valid,
    output vaddr_t      update_start_addr,
    output offset_t     update_size,
    output logic        update_mispred
);

    logic     enq_en;
    logic     fetch_pending;
    logic     fetch_done;
    logic     retire;
    fsq_idx_t commit_head;
    vaddr_t   commit_start_addr;
    offset_t  commit_size;
    logic     commit_truncated;
    offset_t  commit_trunc_offset;

    stream_ram u_stream_ram (
        .clk                 (clk),
        .rst                 (rst),
        .enq_en              (enq_en),
        .enq_idx             (pred_idx),
        .enq_start_addr      (pred_start_addr),
        .enq_size            (pred_size),
        .redirect_en         (redirect_en),
        .redirect_idx        (redirect_idx),
        .redirect_offset     (redirect_offset),
        .search_idx          (fetch_idx),
        .commit_idx          (commit_head),
        .search_start_addr   (fetch_start_addr),
        .search_size         (fetch_size),
        .commit_start_addr   (commit_start_addr),
        .commit_size         (commit_size),
        .commit_truncated    (commit_truncated),
        .commit_trunc_offset (commit_trunc_offset)
    );

    fsq_pointers u_fsq_pointers (
        .clk           (clk),
        .rst           (rst),
        .enq_valid     (pred_valid),
        .redirect_en   (redirect_en),
        .redirect_idx  (redirect_idx),
        .fetch_done    (fetch_done),
        .retire        (retire),
        .tail          (pred_idx),
        .search_head   (fetch_idx),
        .commit_head   (commit_head),
        .full          (pred_stall),
        .fetch_pending (fetch_pending),
        .enq_en        (enq_en)
    );

    fetch_issue u_fetch_issue (
        .clk           (clk),
        .rst           (rst),
        .fetch_pending (fetch_pending),
        .redirect_en   (redirect_en),
        .fetch_ack     (fetch_ack),
        .fetch_req     (fetch_req),
        .fetch_flush   (fetch_flush),
        .fetch_done    (fetch_done)
    );

    commit_tracker u_commit_tracker (
        .clk                 (clk),
        .rst                 (rst),
        .commit_num          (commit_num),
        .commit_start_addr   (commit_start_addr),
        .commit_size         (commit_size),
        .commit_truncated    (commit_truncated),
        .commit_trunc_offset (commit_trunc_offset),
        .retire              (retire),
        .update_valid        (update_valid),
        .update_start_addr   (update_start_addr),
        .update_size         (update_size),
        .update_mispred      (update_mispred)
    );

endmodule

// File: tb_fsq_ref.svh
// model queue of live streams, oldest first
fsq_idx_t m_idx[$];
vaddr_t   m_addr[$];
offset_t  m_size[$];
logic     m_mis[$];
int       m_fetch_pos = 0;
int       m_cnt = 0;
fsq_idx_t m_tail = '0;

// expected update sequence
vaddr_t  exp_addr[$];
offset_t exp_size[$];
logic    exp_mis[$];

function automatic int stream_len(int p);
    return int'(m_size[p]) + 1;
endfunction

function automatic void model_enqueue(vaddr_t a, offset_t s);
    m_idx.push_back(m_tail);
    m_addr.push_back(a);
    m_size.push_back(s);
    m_mis.push_back(1'b0);
    m_tail = fsq_idx_t'(m_tail + 1'b1);
endfunction

// cut everything younger than the mispredicted stream
function automatic void model_redirect(fsq_idx_t r, offset_t off);
    int p;
    p = 0;
    for (int i = 0; i < m_idx.size(); i++) begin
        if (m_idx[i] == r) begin
            p = i;
        end
    end
    m_size[p] = off;
    m_mis[p] = 1'b1;
    while (m_idx.size() > p + 1) begin
        void'(m_idx.pop_back());
        void'(m_addr.pop_back());
        void'(m_size.pop_back());
        void'(m_mis.pop_back());
    end
    if (m_fetch_pos > p + 1) begin
        m_fetch_pos = p + 1;
    end
    m_tail = fsq_idx_t'(r + 1'b1);
endfunction

// retire fetched streams whose instructions are all committed
function automatic void model_commit(commit_num_t n);
    m_cnt += int'(n);
    while (m_fetch_pos > 0 && m_cnt >= stream_len(0)) begin
        m_cnt -= stream_len(0);
        exp_addr.push_back(m_addr.pop_front());
        exp_size.push_back(m_size.pop_front());
        exp_mis.push_back(m_mis.pop_front());
        void'(m_idx.pop_front());
        m_fetch_pos--;
    end
endfunction

function automatic int fetched_insts();
    int sum;
    sum = 0;
    for (int i = 0; i < m_fetch_pos; i++) begin
        sum += stream_len(i);
    end
    return sum - m_cnt;
endfunction

function automatic int queued_insts();
    int sum;
    sum = 0;
    for (int i = 0; i < m_idx.size(); i++) begin
        sum += stream_len(i);
    end
    return sum - m_cnt;
endfunction

task automatic check_addr(string name, vaddr_t got, vaddr_t exp);
    if (got !== exp) begin
        report_fail($sformatf("FAIL %s got 0x%08h expected 0x%08h", name, got, exp));
    end
endtask

task automatic check_offset(string name, offset_t got, offset_t exp);
    if (got !== exp) begin
        report_fail($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
    end
endtask

task automatic check_idx(string name, fsq_idx_t got, fsq_idx_t exp);
    if (got !== exp) begin
        report_fail($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
    end
endtask

task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
        report_fail($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
    end
endtask

task automatic check_fetch();
    if (m_fetch_pos >= m_idx.size()) begin
        report_fail("cache handshake for a stream that should not be fetched");
    end else begin
        check_idx("fetch_idx", fetch_idx, m_idx[m_fetch_pos]);
        check_addr("fetch_start_addr", fetch_start_addr, m_addr[m_fetch_pos]);
        check_offset("fetch_size", fetch_size, m_size[m_fetch_pos]);
        m_fetch_pos++;
    end
endtask

task automatic check_update();
    if (exp_addr.size() == 0) begin
        report_fail("update_valid seen while no retired stream was expected");
    end else begin
        check_addr("update_start_addr", update_start_addr, exp_addr.pop_front());
        check_offset("update_size", update_size, exp_size.pop_front());
        check_bit("update_mispred", update_mispred, exp_mis.pop_front());
    end
endtask

// File: tb_fsq.sv
`timescale 1ns/100ps

module tb_fsq
    import fsq_pkg::*;
;

    // 8 + 16 + 6 + 3 streams
    localparam int planned_streams = 33;
    localparam int cycle_limit = planned_streams * 40 + 500;

    logic        clk;
    logic        rst;
    logic        pred_valid;
    vaddr_t      pred_start_addr;
    offset_t     pred_size;
    logic        pred_stall;
    fsq_idx_t    pred_idx;
    logic        fetch_req;
    logic        fetch_ack = 1'b0;
    logic        fetch_flush;
    fsq_idx_t    fetch_idx;
    vaddr_t      fetch_start_addr;
    offset_t     fetch_size;
    logic        redirect_en;
    fsq_idx_t    redirect_idx;
    offset_t     redirect_offset;
    commit_num_t commit_num;
    logic        update_valid;
    vaddr_t      update_start_addr;
    offset_t     update_size;
    logic        update_mispred;

    logic        hold_ack = 1'b0;
    logic        req_prev = 1'b0;
    logic        ack_prev = 1'b0;
    logic [31:0] lfsr_state = 32'd72833;
    int          ack_wait;
    int          ack_delay;
    int          cycle_cnt = 0;
    int          flush_seen = 0;
    int          enq_seen = 0;

    fsq_top dut0 (.*);

    task automatic report_fail(string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    `include "tb_fsq_ref.svh"

    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h80200003;
        end
        return out;
    endfunction

    function automatic int unsigned rand_bits(int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | 32'(lfsr_bit());
        end
        return v;
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // cache side, ack after 0 to 3 cycles
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            fetch_ack <= 1'b0;
            ack_wait <= 0;
            ack_delay <= 0;
        end else if (fetch_flush || (fetch_ack && !fetch_req)) begin
            fetch_ack <= 1'b0;
            ack_wait <= 0;
        end else if (fetch_req && !fetch_ack && !hold_ack) begin
            if (ack_wait >= ack_delay) begin
                fetch_ack <= 1'b1;
                ack_wait <= 0;
                ack_delay <= int'(rand_bits(2));
            end else begin
                ack_wait <= ack_wait + 1;
            end
        end
    end

    // model update and compare
    always @(posedge clk) begin
        if (!rst) begin
            cycle_cnt++;
            if (cycle_cnt > cycle_limit) begin
                report_fail($sformatf("timeout: run did not finish in %0d cycles", cycle_limit));
            end else if (fetch_req && !req_prev && ack_prev) begin
                // req was launched on the edge where ack was last sampled
                report_fail("fetch_req rose while fetch_ack was still high");
            end else begin
                req_prev = fetch_req;
                ack_prev = fetch_ack;
                if (fetch_flush) begin
                    flush_seen++;
                end
                if (redirect_en) begin
                    model_redirect(redirect_idx, redirect_offset);
                end else begin
                    if (fetch_req && fetch_ack) begin
                        check_fetch();
                    end
                    if (pred_valid && !pred_stall) begin
                        check_idx("pred_idx", pred_idx, m_tail);
                        model_enqueue(pred_start_addr, pred_size);
                        enq_seen++;
                    end
                end
                model_commit(commit_num);
                if (update_valid) begin
                    check_update();
                end
            end
        end
    end

    task automatic push_stream();
        vaddr_t  addr;
        offset_t size;
        @(negedge clk);
        addr = vaddr_t'(rand_bits(30) << 2);
        size = offset_t'(rand_bits(3));
        @(posedge clk);
        pred_valid <= 1'b1;
        pred_start_addr <= addr;
        pred_size <= size;
        @(negedge clk);
        while (pred_stall) begin
            @(negedge clk);
        end
        @(posedge clk);
        pred_valid <= 1'b0;
    endtask

    // commits stay inside the oldest fetched stream, every other cycle
    task automatic commit_insts(int total);
        int left;
        int n;
        left = total;
        while (left > 0) begin
            @(negedge clk);
            n = 0;
            if (commit_num == '0 && m_fetch_pos > 0) begin
                n = int'(rand_bits(3) % (commit_width + 1));
                if (n > stream_len(0) - m_cnt) begin
                    n = stream_len(0) - m_cnt;
                end
                if (n > fetched_insts()) begin
                    n = fetched_insts();
                end
                if (n > left) begin
                    n = left;
                end
            end
            @(posedge clk);
            commit_num <= commit_num_t'(n);
            left -= n;
        end
        @(posedge clk);
        commit_num <= '0;
    endtask

    task automatic wait_drained();
        @(negedge clk);
        while (m_idx.size() != 0 || exp_addr.size() != 0) begin
            @(negedge clk);
        end
    endtask

    initial begin
        int       enq_base;
        int       flush_base;
        int       p;
        fsq_idx_t r;
        offset_t  off;
        rst = 1'b1;
        pred_valid = 1'b0;
        pred_start_addr = '0;
        pred_size = '0;
        redirect_en = 1'b0;
        redirect_idx = '0;
        redirect_offset = '0;
        commit_num = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        // in-order fetch and retire
        for (int i = 0; i < 8; i++) begin
            push_stream();
        end
        @(negedge clk);
        commit_insts(queued_insts());
        wait_drained();

        // fill with the cache stalled
        @(posedge clk);
        hold_ack <= 1'b1;
        @(negedge clk);
        enq_base = enq_seen;
        for (int i = 0; i < fsq_size; i++) begin
            push_stream();
        end
        @(posedge clk);
        pred_valid <= 1'b1;
        repeat (3) @(posedge clk);
        pred_valid <= 1'b0;
        @(negedge clk);
        check_bit("pred_stall", pred_stall, 1'b1);
        if (enq_seen - enq_base != fsq_size) begin
            report_fail("queue did not accept exactly its size in streams");
        end
        @(posedge clk);
        hold_ack <= 1'b0;
        @(negedge clk);
        while (m_fetch_pos == 0) begin
            @(negedge clk);
        end
        commit_insts(stream_len(0));
        @(negedge clk);
        while (pred_stall) begin
            @(negedge clk);
        end
        commit_insts(queued_insts());
        wait_drained();

        // backend redirect into fetched streams
        for (int i = 0; i < 6; i++) begin
            push_stream();
        end
        @(negedge clk);
        while (m_fetch_pos < 4) begin
            @(negedge clk);
        end
        p = int'(rand_bits(4)) % m_fetch_pos;
        r = m_idx[p];
        off = offset_t'(rand_bits(3) % (int'(m_size[p]) + 1));
        flush_base = flush_seen;
        @(posedge clk);
        redirect_en <= 1'b1;
        redirect_idx <= r;
        redirect_offset <= off;
        @(posedge clk);
        redirect_en <= 1'b0;
        @(negedge clk);
        check_idx("pred_idx", pred_idx, fsq_idx_t'(r + 1'b1));
        repeat (3) @(negedge clk);
        if (flush_seen - flush_base != 1) begin
            report_fail("expected exactly one fetch_flush pulse after the redirect");
        end
        for (int i = 0; i < 3; i++) begin
            push_stream();
        end
        @(negedge clk);
        commit_insts(queued_insts());
        wait_drained();

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: flist.f
+incdir+.
fsq_pkg.sv
stream_ram.sv
fsq_pointers.sv
fetch_issue.sv
commit_tracker.sv
fsq_top.sv
tb_fsq.sv

// File: run_sim.sh
#!/bin/sh
# build and run the FSQ testbench with Verilator

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_fsq \
    --Mdir obj_dir -o tb_fsq_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/tb_fsq_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== PASS ===" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
